//--- hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // Major opcodes of the kept RV32I subset
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;

    // ALU operations
    localparam alu_op_t alu_add    = 4'd0;
    localparam alu_op_t alu_sub    = 4'd1;
    localparam alu_op_t alu_and    = 4'd2;
    localparam alu_op_t alu_or     = 4'd3;
    localparam alu_op_t alu_xor    = 4'd4;
    localparam alu_op_t alu_slt    = 4'd5;
    localparam alu_op_t alu_sltu   = 4'd6;
    localparam alu_op_t alu_sll    = 4'd7;
    localparam alu_op_t alu_srl    = 4'd8;
    localparam alu_op_t alu_sra    = 4'd9;
    localparam alu_op_t alu_pass_b = 4'd10;

    // Operand source in decode
    localparam fwd_sel_t fwd_none = 2'd0;
    localparam fwd_sel_t fwd_ex   = 2'd1;
    localparam fwd_sel_t fwd_mem  = 2'd2;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

//--- hdl/rv_core_if.sv
`timescale 1ns/1ns
`default_nettype none

// Destination of the instruction currently held in a stage
interface fwd_if;
    import rv_core_pkg::*;

    reg_addr_t rd;
    logic      wr_en;
    word_t     data;
    logic      is_load;

    modport producer (
        output rd,
        output wr_en,
        output data,
        output is_load
    );

    modport consumer (
        input rd,
        input wr_en,
        input data,
        input is_load
    );

endinterface

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stall,
    input  wire                     interlock,
    input  wire                     flush,
    input  wire                     redirect,
    input  wire rv_core_pkg::word_t target,
    input  wire rv_core_pkg::word_t instr,
    output rv_core_pkg::word_t      pc,
    output rv_core_pkg::word_t      if_pc,
    output rv_core_pkg::word_t      if_instr
);
    import rv_core_pkg::*;

    word_t next_pc;

    assign next_pc = redirect ? target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!interlock && !stall) begin
            pc <= next_pc;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (reset) begin
            if_instr <= nop_instr;
        end else if (!interlock) begin
            if (flush) begin
                if_instr <= nop_instr;
            end else if (!stall) begin
                if_instr <= instr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock && !stall) begin
            if_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         stall,
    input  wire                         interlock,
    input  wire                         flush,
    input  wire rv_core_pkg::word_t     if_pc,
    input  wire rv_core_pkg::word_t     if_instr,
    input  wire rv_core_pkg::fwd_sel_t  fwd1_sel,
    input  wire rv_core_pkg::fwd_sel_t  fwd2_sel,
    input  wire                         wb_en,
    input  wire rv_core_pkg::reg_addr_t wb_rd,
    input  wire rv_core_pkg::word_t     wb_data,
    fwd_if.consumer                     ex_fwd,
    fwd_if.consumer                     mem_fwd,
    output rv_core_pkg::reg_addr_t      rs1,
    output rv_core_pkg::reg_addr_t      rs2,
    output rv_core_pkg::word_t          id_pc,
    output rv_core_pkg::word_t          id_a,
    output rv_core_pkg::word_t          id_b,
    output rv_core_pkg::word_t          id_imm,
    output rv_core_pkg::reg_addr_t      id_rd,
    output rv_core_pkg::alu_op_t        id_alu_op,
    output logic [2:0]                  id_funct3,
    output rv_core_pkg::opcode_t        id_opcode,
    output logic                        id_wr_en
);
    import rv_core_pkg::*;

    opcode_t    opcode;
    reg_addr_t  rd;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm;
    alu_op_t    alu_op;
    logic       wr_en;
    word_t      regs [32];
    word_t      rf1;
    word_t      rf2;
    word_t      op1;
    word_t      op2;

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign alt    = if_instr[30];

    always_comb begin
        case (opcode)
            op_store:  imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            op_branch: imm = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25],
                              if_instr[11:8], 1'b0};
            op_lui:    imm = {if_instr[31:12], 12'b0};
            op_jal:    imm = {{12{if_instr[31]}}, if_instr[19:12], if_instr[20],
                              if_instr[30:21], 1'b0};
            default:   imm = {{20{if_instr[31]}}, if_instr[31:20]};
        endcase
    end

    // Loads, stores and jalr use the adder
    always_comb begin
        alu_op = alu_add;
        if (opcode == op_lui) begin
            alu_op = alu_pass_b;
        end else if (opcode == op_reg || opcode == op_imm) begin
            case (funct3)
                3'b000:  alu_op = (opcode == op_reg && alt) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = alt ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    assign wr_en = opcode inside {op_reg, op_imm, op_lui, op_load, op_jal, op_jalr};

    // Writeback bypassed into the same-cycle register file read
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rf1 = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rf2 = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    always_comb begin
        case (fwd1_sel)
            fwd_ex:  op1 = ex_fwd.data;
            fwd_mem: op1 = mem_fwd.data;
            default: op1 = rf1;
        endcase
        case (fwd2_sel)
            fwd_ex:  op2 = ex_fwd.data;
            fwd_mem: op2 = mem_fwd.data;
            default: op2 = rf2;
        endcase
    end

    // ID/EX
    // A bubble is an addi that writes nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            id_wr_en  <= 1'b0;
            id_opcode <= op_imm;
        end else if (!interlock) begin
            if (stall || flush) begin
                id_wr_en  <= 1'b0;
                id_opcode <= op_imm;
            end else begin
                id_wr_en  <= wr_en;
                id_opcode <= opcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            id_pc     <= if_pc;
            id_a      <= op1;
            id_b      <= op2;
            id_imm    <= imm;
            id_rd     <= rd;
            id_alu_op <= alu_op;
            id_funct3 <= funct3;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  wire rv_core_pkg::reg_addr_t rs1,
    input  wire rv_core_pkg::reg_addr_t rs2,
    input  wire                         redirect,
    input  wire                         acki_n,
    input  wire                         ackd_n,
    input  wire                         mreq,
    fwd_if.consumer                     ex_fwd,
    fwd_if.consumer                     mem_fwd,
    output rv_core_pkg::fwd_sel_t       fwd1_sel,
    output rv_core_pkg::fwd_sel_t       fwd2_sel,
    output logic                        stall,
    output logic                        flush,
    output logic                        interlock
);
    import rv_core_pkg::*;

    logic ex_live;
    logic mem_live;
    logic ex_hit1;
    logic ex_hit2;
    logic mem_hit1;
    logic mem_hit2;

    // x0 is never a producer
    assign ex_live  = ex_fwd.wr_en && ex_fwd.rd != '0;
    assign mem_live = mem_fwd.wr_en && mem_fwd.rd != '0;

    assign ex_hit1  = ex_live && ex_fwd.rd == rs1;
    assign ex_hit2  = ex_live && ex_fwd.rd == rs2;
    assign mem_hit1 = mem_live && mem_fwd.rd == rs1;
    assign mem_hit2 = mem_live && mem_fwd.rd == rs2;

    // Load data does not exist until the memory stage
    assign stall = ex_fwd.is_load && (ex_hit1 || ex_hit2);

    // Youngest producer first
    assign fwd1_sel = (ex_hit1 && !ex_fwd.is_load) ? fwd_ex :
                      mem_hit1                     ? fwd_mem : fwd_none;
    assign fwd2_sel = (ex_hit2 && !ex_fwd.is_load) ? fwd_ex :
                      mem_hit2                     ? fwd_mem : fwd_none;

    assign interlock = acki_n || (mreq && ackd_n);
    assign flush     = redirect && !interlock;

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire rv_core_pkg::alu_op_t op,
    input  wire rv_core_pkg::word_t   a,
    input  wire rv_core_pkg::word_t   b,
    output rv_core_pkg::word_t        y
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_and:    y = a & b;
            alu_or:     y = a | b;
            alu_xor:    y = a ^ b;
            alu_slt:    y = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   y = {31'b0, a < b};
            alu_sll:    y = a << shamt;
            alu_srl:    y = a >> shamt;
            alu_sra:    y = $signed(a) >>> shamt;
            // lui
            alu_pass_b: y = b;
            default:    y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  wire rv_core_pkg::opcode_t opcode,
    input  wire [2:0]                 funct3,
    input  wire rv_core_pkg::word_t   pc,
    input  wire rv_core_pkg::word_t   a,
    input  wire rv_core_pkg::word_t   b,
    input  wire rv_core_pkg::word_t   imm,
    output logic                      taken,
    output rv_core_pkg::word_t        target,
    output rv_core_pkg::word_t        link
);
    import rv_core_pkg::*;

    logic  cond;
    word_t reg_target;

    always_comb begin
        case (funct3)
            3'b000:  cond = a == b;
            3'b001:  cond = a != b;
            3'b100:  cond = $signed(a) < $signed(b);
            3'b101:  cond = $signed(a) >= $signed(b);
            3'b110:  cond = a < b;
            3'b111:  cond = a >= b;
            default: cond = 1'b0;
        endcase
    end

    assign taken = opcode == op_jal || opcode == op_jalr || (opcode == op_branch && cond);

    // jalr clears bit 0 of the sum
    assign reg_target = a + imm;
    assign target     = (opcode == op_jalr) ? {reg_target[31:1], 1'b0} : pc + imm;
    assign link       = pc + 32'd4;

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         interlock,
    input  wire rv_core_pkg::word_t     id_pc,
    input  wire rv_core_pkg::word_t     id_a,
    input  wire rv_core_pkg::word_t     id_b,
    input  wire rv_core_pkg::word_t     id_imm,
    input  wire rv_core_pkg::reg_addr_t id_rd,
    input  wire rv_core_pkg::alu_op_t   id_alu_op,
    input  wire [2:0]                   id_funct3,
    input  wire rv_core_pkg::opcode_t   id_opcode,
    input  wire                         id_wr_en,
    output logic                        redirect,
    output rv_core_pkg::word_t          target,
    fwd_if.producer                     ex_fwd,
    output rv_core_pkg::word_t          ex_result,
    output rv_core_pkg::word_t          ex_store,
    output rv_core_pkg::reg_addr_t      ex_rd,
    output logic                        ex_wr_en,
    output logic                        ex_load,
    output logic                        ex_store_en
);
    import rv_core_pkg::*;

    word_t alu_b;
    word_t alu_y;
    word_t link;
    word_t result;
    logic  taken;
    logic  is_jump;
    logic  is_load;

    // Register operand only for R-type
    assign alu_b = (id_opcode == op_reg) ? id_b : id_imm;

    alu alu_i (
        .op (id_alu_op),
        .a  (id_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    branch_unit branch_unit_i (
        .opcode (id_opcode),
        .funct3 (id_funct3),
        .pc     (id_pc),
        .a      (id_a),
        .b      (id_b),
        .imm    (id_imm),
        .taken  (taken),
        .target (target),
        .link   (link)
    );

    assign is_jump  = id_opcode == op_jal || id_opcode == op_jalr;
    assign is_load  = id_opcode == op_load;
    assign result   = is_jump ? link : alu_y;
    assign redirect = taken;

    assign ex_fwd.rd      = id_rd;
    assign ex_fwd.wr_en   = id_wr_en;
    assign ex_fwd.data    = result;
    assign ex_fwd.is_load = is_load;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_wr_en    <= 1'b0;
            ex_load     <= 1'b0;
            ex_store_en <= 1'b0;
        end else if (!interlock) begin
            ex_wr_en    <= id_wr_en;
            ex_load     <= is_load;
            ex_store_en <= id_opcode == op_store;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            ex_result <= result;
            ex_store  <= id_b;
            ex_rd     <= id_rd;
        end
    end

endmodule

`default_nettype wire

//--- hdl/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         interlock,
    input  wire rv_core_pkg::word_t     ex_result,
    input  wire rv_core_pkg::word_t     ex_store,
    input  wire rv_core_pkg::reg_addr_t ex_rd,
    input  wire                         ex_wr_en,
    input  wire                         ex_load,
    input  wire                         ex_store_en,
    input  wire rv_core_pkg::word_t     ddt_in,
    output rv_core_pkg::word_t          dad,
    output rv_core_pkg::word_t          ddt_out,
    output logic                        mreq,
    output logic                        write,
    fwd_if.producer                     mem_fwd,
    output logic                        wb_en,
    output rv_core_pkg::reg_addr_t      wb_rd,
    output rv_core_pkg::word_t          wb_data
);
    import rv_core_pkg::*;

    word_t mem_data;

    // Held steady by the frozen EX/MEM register while ackd_n is high
    assign dad     = ex_result;
    assign ddt_out = ex_store;
    assign mreq    = ex_load || ex_store_en;
    assign write   = ex_store_en;

    assign mem_data = ex_load ? ddt_in : ex_result;

    assign mem_fwd.rd      = ex_rd;
    assign mem_fwd.wr_en   = ex_wr_en;
    assign mem_fwd.data    = mem_data;
    assign mem_fwd.is_load = ex_load;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else if (!interlock) begin
            wb_en <= ex_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            wb_rd   <= ex_rd;
            wb_data <= mem_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  wire                     clk,
    input  wire                     reset,
    output rv_core_pkg::word_t      iad,
    input  wire rv_core_pkg::word_t idt,
    input  wire                     acki_n,
    output rv_core_pkg::word_t      dad,
    output rv_core_pkg::word_t      ddt_out,
    input  wire rv_core_pkg::word_t ddt_in,
    output logic                    mreq,
    output logic                    write,
    input  wire                     ackd_n
);
    import rv_core_pkg::*;

    logic       stall;
    logic       flush;
    logic       interlock;
    logic       redirect;
    word_t      target;
    word_t      if_pc;
    word_t      if_instr;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    fwd_sel_t   fwd1_sel;
    fwd_sel_t   fwd2_sel;
    logic       wb_en;
    reg_addr_t  wb_rd;
    word_t      wb_data;
    word_t      id_pc;
    word_t      id_a;
    word_t      id_b;
    word_t      id_imm;
    reg_addr_t  id_rd;
    alu_op_t    id_alu_op;
    logic [2:0] id_funct3;
    opcode_t    id_opcode;
    logic       id_wr_en;
    word_t      ex_result;
    word_t      ex_store;
    reg_addr_t  ex_rd;
    logic       ex_wr_en;
    logic       ex_load;
    logic       ex_store_en;

    fwd_if ex_fwd ();
    fwd_if mem_fwd ();

    fetch_stage #(
        .reset_pc (reset_pc)
    ) fetch_stage_i (
        .pc    (iad),
        .instr (idt),
        .*
    );

    decode_stage decode_stage_i (.*);

    hazard_unit hazard_unit_i (.*);

    execute_stage execute_stage_i (.*);

    memory_stage memory_stage_i (.*);

endmodule

`default_nettype wire

//--- testbench/rv_core_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_chk #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input wire                     clk,
    input wire                     reset,
    input wire rv_core_pkg::word_t iad,
    input wire                     acki_n,
    input wire rv_core_pkg::word_t dad,
    input wire rv_core_pkg::word_t ddt_out,
    input wire                     mreq,
    input wire                     write,
    input wire                     ackd_n
);
    import rv_core_pkg::*;

    localparam word_t poison_addr = 32'h0000_03f4;

    int fails = 0;

    bus_stable: assert property (@(posedge clk) disable iff (reset)
        mreq && ackd_n |=> mreq && $stable(dad) && $stable(ddt_out) && $stable(write))
        else begin
            $error("data bus moved during a wait");
            fails++;
        end

    reset_state: assert property (@(posedge clk)
        reset |=> iad == reset_pc && !mreq && !write)
        else begin
            $error("bus not idle after reset");
            fails++;
        end

    no_poison: assert property (@(posedge clk) disable iff (reset)
        mreq && write |-> dad != poison_addr)
        else begin
            $error("store to the poison address");
            fails++;
        end

    iad_stable: assert property (@(posedge clk) disable iff (reset)
        acki_n |=> $stable(iad))
        else begin
            $error("fetch address moved during a wait");
            fails++;
        end

endmodule

bind rv_core rv_core_chk #(.reset_pc(reset_pc)) rv_core_chk_i (.*);

`default_nettype wire

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;
    import rv_core_pkg::*;

    localparam word_t reset_pc = 32'h0000_0080;
    localparam word_t marker   = 32'h0000_03f0;
    localparam word_t poison   = 32'h0000_03f4;

    logic  clk;
    logic  reset;
    word_t iad;
    word_t idt;
    logic  acki_n;
    word_t dad;
    word_t ddt_out;
    word_t ddt_in;
    logic  mreq;
    logic  write;
    logic  ackd_n;

    word_t imem [256];
    word_t dmem [256];
    int    n;
    int    jal_n;
    int    jalr_n;
    bit    waits_on;
    bit    timed_out;
    int    errors;
    int    tests;
    int    failed;
    word_t last_marker;
    int    poison_hits;
    word_t icur;
    int    iwait;
    int    dseq;
    int    dseq_seen;
    bit    dactive;
    int    dwait;

    rv_core #(.reset_pc(reset_pc)) rv_core_i (.*);

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    function automatic word_t fill_word(logic [7:0] i);
        return {i, ~i, i ^ 8'h5a, i ^ 8'ha5};
    endfunction

    function automatic word_t enc_r(logic [31:0] f7, logic [31:0] rs2, logic [31:0] rs1,
                                    logic [31:0] f3, logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
    endfunction

    function automatic word_t enc_i(logic [31:0] imm, logic [31:0] rs1, logic [31:0] f3,
                                    logic [31:0] rd, opcode_t op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_s(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(logic [31:0] imm, logic [31:0] rs2, logic [31:0] rs1,
                                    logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(logic [31:0] imm, logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    function automatic int draw_wait();
        return waits_on ? int'($urandom % 4) : 0;
    endfunction

    function automatic word_t addr_of(int k);
        return reset_pc + 32'(4 * k);
    endfunction

    task automatic put(word_t w);
        logic [7:0] idx;
        idx = reset_pc[9:2] + 8'(n);
        imem[idx] = w;
        n++;
    endtask

    task automatic build_program();
        for (int i = 0; i < 256; i++) imem[i] = enc_i({24'b0, 8'(i)}, 0, 0, 0, op_imm);
        n = 0;
        // Forwarding chain
        put(enc_i(5, 0, 0, 1, op_imm));
        put(enc_i(7, 1, 0, 2, op_imm));
        put(enc_r(32'h20, 1, 2, 0, 3));
        put(enc_i(3, 3, 1, 4, op_imm));
        put(enc_r(0, 2, 4, 4, 5));
        put({20'h12345, 5'd6, op_lui});
        put(enc_r(0, 5, 6, 0, 7));
        put(enc_i(-64, 0, 0, 8, op_imm));
        put(enc_i(32'h402, 8, 5, 9, op_imm));
        put(enc_r(32'h20, 9, 7, 0, 7));
        put(enc_r(0, 1, 9, 2, 11));
        put(enc_r(0, 11, 7, 0, 7));
        put(enc_s(32'h200, 7, 0));
        put(enc_i(1, 0, 0, 10, op_imm));
        put(enc_s(marker, 10, 0));
        // Load-use
        put(enc_i(32'h100, 0, 2, 12, op_load));
        put(enc_i(9, 12, 0, 13, op_imm));
        put(enc_s(32'h204, 13, 0));
        put(enc_i(2, 0, 0, 10, op_imm));
        put(enc_s(marker, 10, 0));
        // Each taken branch skips a poison store
        put(enc_i(3, 0, 0, 14, op_imm));
        put(enc_i(-1, 0, 0, 15, op_imm));
        put(enc_b(8, 14, 14, 0));
        put(enc_s(poison, 0, 0));
        put(enc_b(8, 14, 14, 1));
        put(enc_i(1, 0, 0, 16, op_imm));
        put(enc_b(8, 14, 15, 4));
        put(enc_s(poison, 0, 0));
        put(enc_b(8, 14, 15, 6));
        put(enc_i(2, 16, 0, 16, op_imm));
        put(enc_b(8, 15, 14, 5));
        put(enc_s(poison, 0, 0));
        put(enc_b(8, 14, 15, 7));
        put(enc_s(poison, 0, 0));
        jal_n = n;
        put(enc_j(8, 17));
        put(enc_s(poison, 0, 0));
        put(enc_s(32'h208, 16, 0));
        put(enc_s(32'h20c, 17, 0));
        jalr_n = n;
        put(enc_i(20, 17, 0, 19, op_jalr));
        put(enc_s(poison, 0, 0));
        put(enc_s(32'h210, 19, 0));
        put(enc_i(3, 0, 0, 10, op_imm));
        put(enc_s(marker, 10, 0));
        put(enc_j(0, 0));
    endtask

    // Instruction and data bus responders
    always @(negedge clk) begin
        if (iad != icur) begin
            icur = iad;
            iwait = draw_wait();
        end
        acki_n = iwait > 0;
        if (iwait > 0) iwait--;
        idt = imem[iad[9:2]];
        if (dseq != dseq_seen) begin
            dactive = 0;
            dseq_seen = dseq;
        end
        if (mreq && !dactive) begin
            dactive = 1;
            dwait = draw_wait();
        end
        ackd_n = dactive && dwait > 0;
        if (dactive && dwait > 0) dwait--;
        ddt_in = dmem[dad[9:2]];
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) dmem[i] <= fill_word(8'(i));
            last_marker <= '0;
            poison_hits <= 0;
        end else if (mreq && !ackd_n && !acki_n) begin
            dseq <= dseq + 1;
            if (write && dad == marker) last_marker <= ddt_out;
            else if (write && dad == poison) poison_hits <= poison_hits + 1;
            else if (write) dmem[dad[9:2]] <= ddt_out;
        end
    end

    task automatic apply_reset(bit waits);
        waits_on = waits;
        reset = 1;
        repeat (3) @(negedge clk);
        reset = 0;
    endtask

    task automatic wait_marker(word_t id);
        int t;
        t = 0;
        while (!timed_out && last_marker != id && t < 3000) begin
            @(negedge clk);
            t++;
        end
        if (!timed_out && last_marker != id) begin
            $display("timeout while waiting for marker store %0d", id);
            timed_out = 1;
        end
    endtask

    task automatic check_word(word_t addr, word_t exp);
        if (dmem[addr[9:2]] !== exp) begin
            $display("ERR ddt_out at dad %h: got %h, expected %h", addr, dmem[addr[9:2]], exp);
            errors++;
        end
    endtask

    task automatic report(string name, int e);
        tests++;
        if (errors != e || timed_out) begin
            failed++;
            $display("%s: FAILED", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic check_segment(int id);
        word_t v1;
        word_t v2;
        word_t v7;
        word_t v9;
        v1 = 5;
        v2 = v1 + 7;
        v9 = $signed(32'hffff_ffc0) >>> 2;
        v7 = (32'h12345 << 12) + (((v2 - v1) << 3) ^ v2);
        v7 = v7 - v9 + {31'b0, $signed(v9) < $signed(v1)};
        wait_marker(32'(id));
        if (timed_out) return;
        if (id == 1) check_word(32'h200, v7);
        if (id == 2) check_word(32'h204, fill_word(8'd64) + 9);
        if (id == 3) begin
            check_word(32'h208, 3);
            check_word(32'h20c, addr_of(jal_n) + 4);
            check_word(32'h210, addr_of(jalr_n) + 4);
            if (poison_hits != 0) begin
                $display("a skipped store reached the poison address");
                errors++;
            end
        end
    endtask

    initial begin
        int e;
        reset = 1;
        idt = nop_instr;
        acki_n = 0;
        ddt_in = '0;
        ackd_n = 1;
        icur = '1;
        iwait = 0;
        dseq = 0;
        dseq_seen = 0;
        dactive = 0;
        dwait = 0;
        errors = 0;
        tests = 0;
        failed = 0;
        timed_out = 0;
        void'($urandom(32'h88c9));
        build_program();
        apply_reset(0);
        e = errors;
        if (iad !== reset_pc) begin
            $display("ERR iad: got %h, expected %h", iad, reset_pc);
            errors++;
        end
        if (mreq !== 1'b0 || write !== 1'b0) begin
            $display("ERR mreq/write: got %h/%h, expected 0/0", mreq, write);
            errors++;
        end
        report("test 5 reset state", e);
        e = errors;
        check_segment(1);
        report("test 1 forwarding", e);
        e = errors;
        check_segment(2);
        report("test 2 load-use", e);
        e = errors;
        check_segment(3);
        report("test 3 branches and jumps", e);
        // Same program again with random wait states on both buses
        apply_reset(1);
        e = errors;
        check_segment(1);
        check_segment(2);
        check_segment(3);
        report("test 4 wait states", e);
        $display("tests %0d, failed %0d, assertion failures %0d",
                 tests, failed, rv_core_i.rv_core_chk_i.fails);
        if (failed == 0 && !timed_out && rv_core_i.rv_core_chk_i.fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core.f
hdl/rv_core_pkg.sv
hdl/rv_core_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_core.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
